// File: design/dma_pkg.sv
//--------------------------------------
// Shared definitions of the copy engine
// Bus and length widths, queue depths
// AXI response codes and job types
//--------------------------------------

package dma_pkg;

    //--------------------------------------
    // Widths
    //--------------------------------------
    localparam int unsigned ADDR_W        = 32;
    localparam int unsigned DATA_W        = 32;
    localparam int unsigned STRB_W        = DATA_W / 8;
    // Byte offset within a bus word
    localparam int unsigned WORD_OFFSET_W = 2;
    // Word address, byte offset stripped
    localparam int unsigned WADDR_W       = ADDR_W - WORD_OFFSET_W;
    localparam int unsigned LEN_W         = 16;
    localparam int unsigned WORDS_W       = LEN_W - WORD_OFFSET_W;

    //--------------------------------------
    // Depths
    //--------------------------------------
    // Word buffer between read and write side
    localparam int unsigned BUF_DEPTH     = 4;
    // Each of the two job queues
    localparam int unsigned JOB_DEPTH     = 2;

    // AXI response codes
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

    // Read job, one per accepted non-empty request
    typedef struct packed {
        logic [WADDR_W-1:0] addr;
        logic [WORDS_W-1:0] words;
    } rd_job_t;

    // Write job, one per accepted request
    typedef struct packed {
        logic [WADDR_W-1:0] addr;
        logic [WORDS_W-1:0] words;
        logic               last;
        // Zero-length request, answered without bus traffic
        logic               reject;
    } wr_job_t;

endpackage

// File: design/dma_stream_fifo.sv
//--------------------------------------
// Valid/ready FIFO, generic payload
// Circular buffer, pointers and a count
//--------------------------------------

module dma_stream_fifo #(
    parameter int unsigned DEPTH = 2,
    parameter type         payload_t = logic
) (
    input  logic     clk_i,
    input  logic     reset_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,
    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    // Storage, no reset needed on payload
    payload_t mem_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Full blocks the writer, empty hides the output
    assign in_ready_o  = count_q != CNT_W'(DEPTH);
    assign out_valid_o = count_q != '0;
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i & in_ready_o;
    assign pop  = out_valid_o & out_ready_i;

    // Pointers wrap at DEPTH, count tracks occupancy
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (push & ~pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop & ~push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

// File: design/dma_legalizer.sv
//--------------------------------------
// Request legalizer
// Splits a request into read and write jobs
// Rejects requests of zero words
//--------------------------------------

module dma_legalizer (
    input  logic                      clk_i,
    input  logic                      reset_i,
    // Request side
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic [dma_pkg::ADDR_W-1:0] req_src_addr_i,
    input  logic [dma_pkg::ADDR_W-1:0] req_dst_addr_i,
    input  logic [dma_pkg::LEN_W-1:0]  req_length_i,
    input  logic                      req_last_i,
    // Read job side
    output logic                      rd_valid_o,
    input  logic                      rd_ready_i,
    output dma_pkg::rd_job_t          rd_job_o,
    // Write job side
    output logic                      wr_valid_o,
    input  logic                      wr_ready_i,
    output dma_pkg::wr_job_t          wr_job_o,
    output logic                      busy_o
);

    import dma_pkg::*;

    logic                req_hs;
    logic [WORDS_W-1:0]  words;
    logic                is_empty;

    // One pending flag per side, so each is accepted on its own
    logic    rd_pend_q;
    logic    wr_pend_q;
    rd_job_t rd_job_q;
    wr_job_t wr_job_q;

    //--------------------------------------
    // Length conversion
    //--------------------------------------
    // Byte count to whole words, low bits dropped
    assign words    = req_length_i[LEN_W-1:WORD_OFFSET_W];
    assign is_empty = words == '0;

    // New request only once both jobs of the previous one left
    assign req_ready_o = ~rd_pend_q & ~wr_pend_q;
    assign req_hs      = req_valid_i & req_ready_o;

    assign rd_valid_o = rd_pend_q;
    assign wr_valid_o = wr_pend_q;
    assign rd_job_o   = rd_job_q;
    assign wr_job_o   = wr_job_q;
    assign busy_o     = rd_pend_q | wr_pend_q;

    //--------------------------------------
    // Pending flags
    //--------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_pend_q <= 1'b0;
            wr_pend_q <= 1'b0;
        end else if (req_hs) begin
            // Empty request skips the read side entirely
            rd_pend_q <= ~is_empty;
            wr_pend_q <= 1'b1;
        end else begin
            if (rd_ready_i) begin
                rd_pend_q <= 1'b0;
            end
            if (wr_ready_i) begin
                wr_pend_q <= 1'b0;
            end
        end
    end

    // Job payloads
    always_ff @(posedge clk_i) begin
        if (req_hs) begin
            rd_job_q.addr    <= req_src_addr_i[ADDR_W-1:WORD_OFFSET_W];
            rd_job_q.words   <= words;
            wr_job_q.addr    <= req_dst_addr_i[ADDR_W-1:WORD_OFFSET_W];
            wr_job_q.words   <= words;
            wr_job_q.last    <= req_last_i;
            wr_job_q.reject  <= is_empty;
        end
    end

endmodule

// File: design/dma_read_engine.sv
//--------------------------------------
// Read engine
// AR and R of the AXI4-Lite port
// Pushes words and read errors to buffer
//--------------------------------------

module dma_read_engine (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Read job queue
    input  logic                        job_valid_i,
    output logic                        job_ready_o,
    input  dma_pkg::rd_job_t            job_i,
    // Word buffer, read error bit on top
    output logic                        buf_valid_o,
    input  logic                        buf_ready_i,
    output logic [dma_pkg::DATA_W:0]    buf_data_o,
    // AXI4-Lite read channels
    output logic [dma_pkg::ADDR_W-1:0]  m_axi_araddr_o,
    output logic                        m_axi_arvalid_o,
    input  logic                        m_axi_arready_i,
    input  logic [dma_pkg::DATA_W-1:0]  m_axi_rdata_i,
    input  logic [1:0]                  m_axi_rresp_i,
    input  logic                        m_axi_rvalid_i,
    output logic                        m_axi_rready_o,
    output logic                        busy_o
);

    import dma_pkg::*;

    typedef enum logic [1:0] {RD_IDLE, RD_ADDR, RD_DATA} rd_state_e;

    rd_state_e          state_q;
    logic [WADDR_W-1:0] addr_q;
    logic [WORDS_W-1:0] count_q;
    logic               ar_hs;
    logic               r_hs;

    // AR waits for a free buffer slot, only this engine fills it
    assign m_axi_arvalid_o = (state_q == RD_ADDR) & buf_ready_i;
    assign m_axi_araddr_o  = {addr_q, {WORD_OFFSET_W{1'b0}}};
    assign ar_hs           = m_axi_arvalid_o & m_axi_arready_i;

    // R goes straight into the buffer
    assign m_axi_rready_o = (state_q == RD_DATA) & buf_ready_i;
    assign r_hs           = m_axi_rvalid_i & m_axi_rready_o;
    assign buf_valid_o    = (state_q == RD_DATA) & m_axi_rvalid_i;
    assign buf_data_o     = {m_axi_rresp_i != AXI_RESP_OKAY, m_axi_rdata_i};

    // Job stays at the queue head until its last R
    assign job_ready_o = r_hs & (count_q == WORDS_W'(1));
    assign busy_o      = state_q != RD_IDLE;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= RD_IDLE;
        end else begin
            case (state_q)
                RD_IDLE: if (job_valid_i) state_q <= RD_ADDR;
                RD_ADDR: if (ar_hs) state_q <= RD_DATA;
                RD_DATA: begin
                    if (r_hs) begin
                        state_q <= job_ready_o ? RD_IDLE : RD_ADDR;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    // Address and remaining words
    always_ff @(posedge clk_i) begin
        if (state_q == RD_IDLE && job_valid_i) begin
            addr_q  <= job_i.addr;
            count_q <= job_i.words;
        end else if (r_hs) begin
            addr_q  <= addr_q + 1'b1;
            count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: design/dma_write_engine.sv
//--------------------------------------
// Write engine
// AW, W and B of the AXI4-Lite port
// One response per write job
//--------------------------------------

module dma_write_engine (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Write job queue
    input  logic                        job_valid_i,
    output logic                        job_ready_o,
    input  dma_pkg::wr_job_t            job_i,
    // Word buffer
    input  logic                        buf_valid_i,
    output logic                        buf_ready_o,
    input  logic [dma_pkg::DATA_W:0]    buf_data_i,
    // AXI4-Lite write channels
    output logic [dma_pkg::ADDR_W-1:0]  m_axi_awaddr_o,
    output logic                        m_axi_awvalid_o,
    input  logic                        m_axi_awready_i,
    output logic [dma_pkg::DATA_W-1:0]  m_axi_wdata_o,
    output logic [dma_pkg::STRB_W-1:0]  m_axi_wstrb_o,
    output logic                        m_axi_wvalid_o,
    input  logic                        m_axi_wready_i,
    input  logic [1:0]                  m_axi_bresp_i,
    input  logic                        m_axi_bvalid_i,
    output logic                        m_axi_bready_o,
    // Response
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    output logic                        rsp_error_o,
    output logic                        rsp_last_o,
    output logic                        busy_o
);

    import dma_pkg::*;

    typedef enum logic [1:0] {WR_IDLE, WR_WRITE, WR_RESP, WR_REPORT} wr_state_e;

    wr_state_e          state_q;
    logic [WADDR_W-1:0] addr_q;
    logic [WORDS_W-1:0] count_q;
    logic               last_q;
    // Sticky error of the current job
    logic               err_q;
    logic               aw_done_q;
    logic               w_done_q;
    logic               aw_ok;
    logic               w_ok;

    //--------------------------------------
    // AW and W, each completes on its own
    //--------------------------------------
    assign m_axi_awvalid_o = (state_q == WR_WRITE) & buf_valid_i & ~aw_done_q;
    assign m_axi_wvalid_o  = (state_q == WR_WRITE) & buf_valid_i & ~w_done_q;
    assign m_axi_awaddr_o  = {addr_q, {WORD_OFFSET_W{1'b0}}};
    assign m_axi_wdata_o   = buf_data_i[DATA_W-1:0];
    // Full words only
    assign m_axi_wstrb_o   = '1;

    assign aw_ok = aw_done_q | (m_axi_awvalid_o & m_axi_awready_i);
    assign w_ok  = w_done_q | (m_axi_wvalid_o & m_axi_wready_i);

    // Word leaves the buffer once both channels took it
    assign buf_ready_o    = (state_q == WR_WRITE) & buf_valid_i & aw_ok & w_ok;
    assign m_axi_bready_o = state_q == WR_RESP;
    assign job_ready_o    = state_q == WR_IDLE;

    assign rsp_valid_o = state_q == WR_REPORT;
    assign rsp_error_o = err_q;
    assign rsp_last_o  = last_q;
    assign busy_o      = state_q != WR_IDLE;

    //--------------------------------------
    // FSM
    //--------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q   <= WR_IDLE;
            err_q     <= 1'b0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            case (state_q)
                WR_IDLE: begin
                    if (job_valid_i) begin
                        // Rejected job goes straight to its response
                        err_q   <= job_i.reject;
                        state_q <= job_i.reject ? WR_REPORT : WR_WRITE;
                    end
                end
                WR_WRITE: begin
                    if (buf_ready_o) begin
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                        // Read error travels with the word
                        err_q     <= err_q | buf_data_i[DATA_W];
                        state_q   <= WR_RESP;
                    end else begin
                        aw_done_q <= aw_ok;
                        w_done_q  <= w_ok;
                    end
                end
                WR_RESP: begin
                    if (m_axi_bvalid_i) begin
                        err_q   <= err_q | (m_axi_bresp_i != AXI_RESP_OKAY);
                        state_q <= (count_q == WORDS_W'(1)) ? WR_REPORT : WR_WRITE;
                    end
                end
                WR_REPORT: if (rsp_ready_i) state_q <= WR_IDLE;
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    // Destination address, remaining words, last flag
    always_ff @(posedge clk_i) begin
        if (state_q == WR_IDLE && job_valid_i) begin
            addr_q  <= job_i.addr;
            count_q <= job_i.words;
            last_q  <= job_i.last;
        end else if (m_axi_bready_o && m_axi_bvalid_i) begin
            addr_q  <= addr_q + 1'b1;
            count_q <= count_q - 1'b1;
        end
    end

endmodule

// File: design/dma_backend.sv
//--------------------------------------
// Copy engine top level
// Legalizer, job queues, word buffer
// Read and write engines on AXI4-Lite
//--------------------------------------

module dma_backend (
    input  logic                        clk_i,
    input  logic                        reset_i,
    // Request
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  logic [dma_pkg::ADDR_W-1:0]  req_src_addr_i,
    input  logic [dma_pkg::ADDR_W-1:0]  req_dst_addr_i,
    input  logic [dma_pkg::LEN_W-1:0]   req_length_i,
    input  logic                        req_last_i,
    // Response
    output logic                        rsp_valid_o,
    input  logic                        rsp_ready_i,
    output logic                        rsp_error_o,
    output logic                        rsp_last_o,
    // AXI4-Lite manager
    output logic [dma_pkg::ADDR_W-1:0]  m_axi_araddr_o,
    output logic                        m_axi_arvalid_o,
    input  logic                        m_axi_arready_i,
    input  logic [dma_pkg::DATA_W-1:0]  m_axi_rdata_i,
    input  logic [1:0]                  m_axi_rresp_i,
    input  logic                        m_axi_rvalid_i,
    output logic                        m_axi_rready_o,
    output logic [dma_pkg::ADDR_W-1:0]  m_axi_awaddr_o,
    output logic                        m_axi_awvalid_o,
    input  logic                        m_axi_awready_i,
    output logic [dma_pkg::DATA_W-1:0]  m_axi_wdata_o,
    output logic [dma_pkg::STRB_W-1:0]  m_axi_wstrb_o,
    output logic                        m_axi_wvalid_o,
    input  logic                        m_axi_wready_i,
    input  logic [1:0]                  m_axi_bresp_i,
    input  logic                        m_axi_bvalid_i,
    output logic                        m_axi_bready_o,
    // Busy flags
    output logic                        busy_rd_o,
    output logic                        busy_wr_o
);

    import dma_pkg::*;

    // Legalizer to job queues
    logic    leg_rd_valid, leg_rd_ready, leg_wr_valid, leg_wr_ready, leg_busy;
    rd_job_t leg_rd_job;
    wr_job_t leg_wr_job;
    // Job queues to engines
    logic    rd_job_valid, rd_job_ready, wr_job_valid, wr_job_ready;
    rd_job_t rd_job;
    wr_job_t wr_job;
    // Word buffer, data plus read error
    logic              bin_valid, bin_ready, bout_valid, bout_ready;
    logic [DATA_W:0]   bin_data;
    logic [DATA_W:0]   bout_data;
    logic              rd_busy;

    dma_legalizer i_legalizer (
        .clk_i, .reset_i, .req_valid_i, .req_ready_o,
        .req_src_addr_i, .req_dst_addr_i, .req_length_i, .req_last_i,
        .rd_valid_o ( leg_rd_valid ), .rd_ready_i ( leg_rd_ready ), .rd_job_o ( leg_rd_job ),
        .wr_valid_o ( leg_wr_valid ), .wr_ready_i ( leg_wr_ready ), .wr_job_o ( leg_wr_job ),
        .busy_o     ( leg_busy     )
    );

    //--------------------------------------
    // Decoupling queues
    //--------------------------------------
    dma_stream_fifo #(.DEPTH(JOB_DEPTH), .payload_t(rd_job_t)) i_rd_job_fifo (
        .clk_i, .reset_i,
        .in_valid_i  ( leg_rd_valid ), .in_ready_o  ( leg_rd_ready ), .in_data_i  ( leg_rd_job ),
        .out_valid_o ( rd_job_valid ), .out_ready_i ( rd_job_ready ), .out_data_o ( rd_job     )
    );

    dma_stream_fifo #(.DEPTH(JOB_DEPTH), .payload_t(wr_job_t)) i_wr_job_fifo (
        .clk_i, .reset_i,
        .in_valid_i  ( leg_wr_valid ), .in_ready_o  ( leg_wr_ready ), .in_data_i  ( leg_wr_job ),
        .out_valid_o ( wr_job_valid ), .out_ready_i ( wr_job_ready ), .out_data_o ( wr_job     )
    );

    dma_stream_fifo #(.DEPTH(BUF_DEPTH), .payload_t(logic [DATA_W:0])) i_buf_fifo (
        .clk_i, .reset_i,
        .in_valid_i  ( bin_valid  ), .in_ready_o  ( bin_ready  ), .in_data_i  ( bin_data  ),
        .out_valid_o ( bout_valid ), .out_ready_i ( bout_ready ), .out_data_o ( bout_data )
    );

    //--------------------------------------
    // Engines
    //--------------------------------------
    dma_read_engine i_read_engine (
        .clk_i, .reset_i,
        .job_valid_i ( rd_job_valid ), .job_ready_o ( rd_job_ready ), .job_i ( rd_job ),
        .buf_valid_o ( bin_valid    ), .buf_ready_i ( bin_ready    ), .buf_data_o ( bin_data ),
        .m_axi_araddr_o, .m_axi_arvalid_o, .m_axi_arready_i,
        .m_axi_rdata_i, .m_axi_rresp_i, .m_axi_rvalid_i, .m_axi_rready_o,
        .busy_o      ( rd_busy      )
    );

    dma_write_engine i_write_engine (
        .clk_i, .reset_i,
        .job_valid_i ( wr_job_valid ), .job_ready_o ( wr_job_ready ), .job_i ( wr_job ),
        .buf_valid_i ( bout_valid   ), .buf_ready_o ( bout_ready   ), .buf_data_i ( bout_data ),
        .m_axi_awaddr_o, .m_axi_awvalid_o, .m_axi_awready_i,
        .m_axi_wdata_o, .m_axi_wstrb_o, .m_axi_wvalid_o, .m_axi_wready_i,
        .m_axi_bresp_i, .m_axi_bvalid_i, .m_axi_bready_o,
        .rsp_valid_o, .rsp_ready_i, .rsp_error_o, .rsp_last_o,
        .busy_o      ( busy_wr_o    )
    );

    // Read side covers legalizer and read engine
    assign busy_rd_o = leg_busy | rd_busy;

endmodule

// File: sim/axi_lite_mem_model.sv
//--------------------------------------
// AXI4-Lite memory subordinate, 256 words
// Random ready stalls on AR, AW and W
// SLVERR at word 240 and above
//--------------------------------------

module axi_lite_mem_model (
    input  logic        clk_i,
    input  logic        reset_i,
    // Read channels
    input  logic [31:0] araddr_i,
    input  logic        arvalid_i,
    output logic        arready_o,
    output logic [31:0] rdata_o,
    output logic [1:0]  rresp_o,
    output logic        rvalid_o,
    input  logic        rready_i,
    // Write channels
    input  logic [31:0] awaddr_i,
    input  logic        awvalid_i,
    output logic        awready_o,
    input  logic [31:0] wdata_i,
    input  logic [3:0]  wstrb_i,
    input  logic        wvalid_i,
    output logic        wready_o,
    output logic [1:0]  bresp_o,
    output logic        bvalid_o,
    input  logic        bready_i
);

    import dma_pkg::*;

    localparam int unsigned ERR_BASE = 240;

    // Contents, loaded by the testbench before reset ends
    logic [31:0] mem_q [256];

    logic        ar_rand = 1'b0;
    logic        aw_rand = 1'b0;
    logic        w_rand  = 1'b0;
    logic        aw_have_q;
    logic        w_have_q;
    logic [31:0] aw_addr_q;
    logic [31:0] w_data_q;
    logic [3:0]  w_strb_q;

    // Outside the 1 KiB window or inside the top 16 words
    function automatic logic is_err(input logic [31:0] addr);
        return (addr[31:10] != '0) || (addr[9:2] >= 8'(ERR_BASE));
    endfunction

    // One request at a time per direction
    assign arready_o = ar_rand & ~rvalid_o;
    assign awready_o = aw_rand & ~aw_have_q & ~bvalid_o;
    assign wready_o  = w_rand & ~w_have_q & ~bvalid_o;

    // Ready stalls change on the falling edge
    always @(negedge clk_i) begin
        ar_rand <= ($urandom % 3) != 0;
        aw_rand <= ($urandom % 3) != 0;
        w_rand  <= ($urandom % 2) != 0;
    end

    always @(posedge clk_i) begin
        if (reset_i) begin
            rvalid_o  <= 1'b0;
            rdata_o   <= '0;
            rresp_o   <= AXI_RESP_OKAY;
            bvalid_o  <= 1'b0;
            bresp_o   <= AXI_RESP_OKAY;
            aw_have_q <= 1'b0;
            w_have_q  <= 1'b0;
            aw_addr_q <= '0;
            w_data_q  <= '0;
            w_strb_q  <= '0;
        end else begin
            //--------------------------------------
            // Read side
            //--------------------------------------
            if (rvalid_o && rready_i) begin
                rvalid_o <= 1'b0;
            end
            if (arvalid_i && arready_o) begin
                rvalid_o <= 1'b1;
                rdata_o  <= is_err(araddr_i) ? '0 : mem_q[araddr_i[9:2]];
                rresp_o  <= is_err(araddr_i) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
            end
            //--------------------------------------
            // Write side
            //--------------------------------------
            if (bvalid_o && bready_i) begin
                bvalid_o <= 1'b0;
            end
            if (awvalid_i && awready_o) begin
                aw_have_q <= 1'b1;
                aw_addr_q <= awaddr_i;
            end
            if (wvalid_i && wready_o) begin
                w_have_q <= 1'b1;
                w_data_q <= wdata_i;
                w_strb_q <= wstrb_i;
            end
            // Both halves in, commit and answer on B
            if (aw_have_q && w_have_q) begin
                aw_have_q <= 1'b0;
                w_have_q  <= 1'b0;
                bvalid_o  <= 1'b1;
                bresp_o   <= is_err(aw_addr_q) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
                if (!is_err(aw_addr_q)) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w_strb_q[b]) begin
                            mem_q[aw_addr_q[9:2]][8*b +: 8] <= w_data_q[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

// File: sim/tb_dma_backend.sv
//--------------------------------------
// Testbench of the copy engine
// Random requests, memory reference model
// Response, busy and memory checks
//--------------------------------------

module tb_dma_backend;

    import dma_pkg::*;

    localparam int N_REQ   = 50;
    localparam int TIMEOUT = 2000;

    logic        clk;
    logic        reset;
    logic        req_valid, req_ready, req_last;
    logic [31:0] req_src, req_dst;
    logic [15:0] req_len;
    logic        rsp_valid, rsp_ready, rsp_error, rsp_last;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic        arvalid, arready, rvalid, rready, awvalid, awready;
    logic        wvalid, wready, bvalid, bready;
    logic [1:0]  rresp, bresp;
    logic [3:0]  wstrb;
    logic        busy_rd, busy_wr;

    // Reference memory, updated in request order
    logic [31:0] model_mem [256];
    bit          exp_err_q [$];
    bit          exp_last_q [$];
    int          rsp_count;
    bit          stall_seen;

    dma_backend dut0 (
        .clk_i (clk), .reset_i (reset),
        .req_valid_i (req_valid), .req_ready_o (req_ready),
        .req_src_addr_i (req_src), .req_dst_addr_i (req_dst),
        .req_length_i (req_len), .req_last_i (req_last),
        .rsp_valid_o (rsp_valid), .rsp_ready_i (rsp_ready),
        .rsp_error_o (rsp_error), .rsp_last_o (rsp_last),
        .m_axi_araddr_o (araddr), .m_axi_arvalid_o (arvalid), .m_axi_arready_i (arready),
        .m_axi_rdata_i (rdata), .m_axi_rresp_i (rresp), .m_axi_rvalid_i (rvalid),
        .m_axi_rready_o (rready),
        .m_axi_awaddr_o (awaddr), .m_axi_awvalid_o (awvalid), .m_axi_awready_i (awready),
        .m_axi_wdata_o (wdata), .m_axi_wstrb_o (wstrb), .m_axi_wvalid_o (wvalid),
        .m_axi_wready_i (wready),
        .m_axi_bresp_i (bresp), .m_axi_bvalid_i (bvalid), .m_axi_bready_o (bready),
        .busy_rd_o (busy_rd), .busy_wr_o (busy_wr)
    );

    axi_lite_mem_model mem0 (
        .clk_i (clk), .reset_i (reset),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
        .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Start pattern, every byte tied to the word address
    function automatic logic [31:0] fill_word(input int unsigned i);
        return {8'hc3, i[7:0] ^ 8'h3c, ~i[7:0], i[7:0]};
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // Sequential copy, error from rejection, R and B errors
    task automatic model_copy(input int src, input int dst, input int words, input bit last);
        bit          err;
        logic [31:0] data;
        err = (words == 0);
        for (int k = 0; k < words; k++) begin
            data = (src + k >= 240) ? 32'h0 : model_mem[src + k];
            if (src + k >= 240) err = 1'b1;
            if (dst + k >= 240) begin
                err = 1'b1;
            end else begin
                model_mem[dst + k] = data;
            end
        end
        exp_err_q.push_back(err);
        exp_last_q.push_back(last);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send_request(input int src, input int dst, input int len);
        int cnt;
        req_valid = 1'b1;
        req_src   = src * 4;
        req_dst   = dst * 4;
        req_len   = 16'(len);
        req_last  = $urandom % 2;
        model_copy(src, dst, len / 4, req_last);
        cnt = 0;
        while (!req_ready) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("Request was never accepted");
        end
        @(negedge clk);
        req_valid = 1'b0;
        repeat ($urandom % 3) @(negedge clk);
    endtask

    task automatic send_normal();
        int words;
        words = 1 + $urandom % 8;
        send_request($urandom % 113, 120 + $urandom % 109, words * 4 + $urandom % 4);
    endtask

    //--------------------------------------
    // Response monitor
    //--------------------------------------
    initial begin
        int wait_cnt;
        int stall_left;
        int held_cnt;
        wait_cnt   = 0;
        stall_left = 0;
        held_cnt   = 0;
        rsp_count  = 0;
        stall_seen = 1'b0;
        rsp_ready  = 1'b0;
        while (rsp_count < N_REQ) begin
            @(negedge clk);
            if (stall_left > 0) begin
                rsp_ready = 1'b0;
                stall_left--;
            end else begin
                rsp_ready = ($urandom % 4) != 0;
            end
            // Request side backs up behind a long held response
            if (rsp_valid && !rsp_ready) begin
                held_cnt++;
            end else begin
                held_cnt = 0;
            end
            if (held_cnt > 40 && !req_ready) stall_seen = 1'b1;
            if (rsp_valid && rsp_ready) begin
                if (exp_err_q.size() == 0) fail_run("Response with no request outstanding");
                check_value("rsp_error_o", rsp_error, exp_err_q.pop_front());
                check_value("rsp_last_o", rsp_last, exp_last_q.pop_front());
                rsp_count++;
                wait_cnt = 0;
                if (rsp_count == 20) begin
                    stall_left = 80;
                end else if ($urandom % 5 == 0) begin
                    stall_left = $urandom % 20;
                end
            end else begin
                wait_cnt++;
                if (wait_cnt > TIMEOUT) fail_run("Timed out waiting for a response");
            end
        end
    end

    //--------------------------------------
    // Driver and final checks
    //--------------------------------------
    initial begin
        int cnt;
        void'($urandom(32'hd7c1));
        reset     = 1'b1;
        req_valid = 1'b0;
        req_src   = '0;
        req_dst   = '0;
        req_len   = '0;
        req_last  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            model_mem[i]  = fill_word(i);
            mem0.mem_q[i] = fill_word(i);
        end
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // Idle outputs right after reset
        check_value("req_ready_o", req_ready, 1);
        check_value("rsp_valid_o", rsp_valid, 0);
        check_value("busy_rd_o", busy_rd, 0);
        check_value("busy_wr_o", busy_wr, 0);
        check_value("m_axi_arvalid_o", arvalid, 0);
        check_value("m_axi_rready_o", rready, 0);
        check_value("m_axi_awvalid_o", awvalid, 0);
        check_value("m_axi_wvalid_o", wvalid, 0);
        check_value("m_axi_bready_o", bready, 0);
        check_value("m_axi_wstrb_o", wstrb, 4'hf);

        for (int i = 0; i < 20; i++) send_normal();
        // Below one word, rejected
        for (int i = 0; i < 4; i++) begin
            send_request($urandom % 113, 120 + $urandom % 109, $urandom % 4);
        end
        // Source or destination in the error region
        for (int i = 0; i < 6; i++) begin
            if (i % 2 == 0) begin
                send_request(240 + $urandom % 8, 120 + $urandom % 109, 4 * (1 + $urandom % 8));
            end else begin
                send_request($urandom % 113, 236 + $urandom % 12, 4 * (1 + $urandom % 8));
            end
        end
        for (int i = 0; i < 20; i++) send_normal();

        cnt = 0;
        while (rsp_count < N_REQ) begin
            @(negedge clk);
            cnt++;
            if (cnt > 20 * TIMEOUT) fail_run("Not all responses arrived");
        end
        cnt = 0;
        while (busy_rd || busy_wr) begin
            @(negedge clk);
            cnt++;
            if (cnt > TIMEOUT) fail_run("Busy flags stayed high after the last response");
        end
        check_value("m_axi_arvalid_o", arvalid, 0);
        check_value("m_axi_awvalid_o", awvalid, 0);
        check_value("m_axi_wvalid_o", wvalid, 0);
        if (!stall_seen) fail_run("Request port never stalled while a response was held");
        for (int i = 0; i < 256; i++) begin
            check_value($sformatf("mem[%0d]", i), mem0.mem_q[i], model_mem[i]);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: dma_backend.f
design/dma_pkg.sv
design/dma_stream_fifo.sv
design/dma_legalizer.sv
design/dma_read_engine.sv
design/dma_write_engine.sv
design/dma_backend.sv
sim/axi_lite_mem_model.sv
sim/tb_dma_backend.sv

// File: run.sh
#!/bin/sh
# Build and run the copy engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f dma_backend.f --top-module tb_dma_backend -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_dma_backend)
rc=$?
echo "$out"
if [ $rc -ne 0 ]; then
    echo "Simulation exited with status $rc"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1
